/* logic/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

`define CORE_XLEN 32 // data and address width in bits.

`define CORE_RESET_PC 32'h0000_0000 // first fetch address after reset.

`endif

/* logic/coreTypesPkg.sv */
`include "core_params.svh"

package coreTypesPkg;

  typedef logic [`CORE_XLEN-1:0] word;

  // Branch class of the instruction as seen by the decoder.
  typedef enum logic [1:0] {
    nonType         = 2'b00,
    jalType         = 2'b01,
    jalrType        = 2'b10,
    conditionalType = 2'b11
  } branchKind;

  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branchCond; // values follow funct3.

  typedef struct packed {
    branchKind kind;
    branchCond cond;
    logic      isLoad;
    word       imm; // byte offset.
    word       pc;
    word       rs1;
    word       rs2;
  } decodeBundle;

  typedef struct packed {
    logic zero;
    logic neg; // rs1 < rs2 as signed values.
    logic negu; // rs1 < rs2 as unsigned values.
    word  jumpTarget;
  } compareFlags;

  // Controls from the branch unit to the fetch PC and the stage latch.
  typedef struct packed {
    logic flush;
    logic hold;
    logic branch; // next PC is pcCurrent plus pcNext.
    logic bypass; // next PC is pcNext as an absolute address.
    word  pcNext;
    word  pcCurrent;
  } branchingOut;

endpackage

/* logic/compareUnit.sv */
`timescale 1ns/1ps

`include "core_params.svh"

module compareUnit (
  input  coreTypesPkg::decodeBundle exec,
  output coreTypesPkg::compareFlags flags
);

  logic [`CORE_XLEN:0]   difference; // one extra bit keeps the borrow.
  logic [`CORE_XLEN-1:0] targetSum;
  logic                  signsDiffer;

  assign difference = {1'b0, exec.rs1} - {1'b0, exec.rs2};
  assign signsDiffer = exec.rs1[`CORE_XLEN-1] ^ exec.rs2[`CORE_XLEN-1];

  assign flags.zero = (difference[`CORE_XLEN-1:0] == '0);
  assign flags.negu = difference[`CORE_XLEN]; // a borrow means rs1 is below rs2.

  // With equal signs the subtraction cannot overflow, so its sign bit decides.
  assign flags.neg = signsDiffer ? exec.rs1[`CORE_XLEN-1] : difference[`CORE_XLEN-1];

  assign targetSum = exec.rs1 + exec.imm;

  // Fetch is word-aligned, so the low bits of the jump target are dropped.
  assign flags.jumpTarget = {targetSum[`CORE_XLEN-1:2], 2'b00};

  // Equal operands can never also compare as less-than.
  zeroExcludesLess : assert final (!flags.zero || !(flags.neg || flags.negu))
    else $error("compareUnit: zero set together with a less-than flag.");

endmodule

/* logic/decodeExecuteStage.sv */
`timescale 1ns/1ps

module decodeExecuteStage (
  input  logic                      Clock,
  input  logic                      nReset,
  input  coreTypesPkg::decodeBundle decodeIn,
  input  coreTypesPkg::branchingOut control,
  output coreTypesPkg::decodeBundle decodeNow,
  output coreTypesPkg::decodeBundle execNow
);

  localparam coreTypesPkg::decodeBundle BubbleBundle = '{
    kind:   coreTypesPkg::nonType,
    cond:   coreTypesPkg::beq,
    isLoad: 1'b0,
    imm:    '0,
    pc:     '0,
    rs1:    '0,
    rs2:    '0
  };

  logic                      replay;
  logic                      plainStall;
  coreTypesPkg::decodeBundle execReg;

  // A stall without a redirect presents the same instruction again next cycle.
  assign plainStall = control.hold && !control.branch && !control.bypass;

  // The refetched copy was already issued, so it is turned into a bubble.
  assign decodeNow = replay ? BubbleBundle : decodeIn;

  assign execNow = execReg;

  always_ff @(posedge Clock or negedge nReset) begin
    if (!nReset) begin
      replay  <= 1'b0;
      execReg <= BubbleBundle;
    end else begin
      replay <= plainStall;
      if (control.flush) begin
        execReg <= BubbleBundle; // the wrong-path instruction is squashed.
      end else begin
        execReg <= decodeNow;
      end
    end
  end

  // The masked copy must not stall fetch a second time.
  replayDoesNotHold : assert property (
    @(posedge Clock) disable iff (!nReset)
    replay |-> !control.hold
  ) else $error("decodeExecuteStage: replayed decode raised hold again.");

endmodule

/* logic/branching.sv */
`timescale 1ns/1ps

module branching (
  input  logic                      Clock,
  input  logic                      nReset,
  input  coreTypesPkg::decodeBundle decodeNow,
  input  coreTypesPkg::decodeBundle execNow,
  input  coreTypesPkg::compareFlags flags,
  output coreTypesPkg::branchingOut control
);

  logic predictReg; // one-bit taken/not-taken predictor.
  logic predictNow;
  logic taken;
  logic mispredict;

  always_ff @(posedge Clock or negedge nReset) begin
    if (!nReset) begin
      predictReg <= 1'b0; // start out predicting not taken.
    end else begin
      predictReg <= predictNow;
    end
  end

  // Outcome of the conditional branch sitting in execute.
  always_comb begin
    case (execNow.cond)
      coreTypesPkg::beq:  taken = flags.zero;
      coreTypesPkg::bne:  taken = !flags.zero;
      coreTypesPkg::blt:  taken = flags.neg;
      coreTypesPkg::bge:  taken = !flags.neg;
      coreTypesPkg::bltu: taken = flags.negu;
      coreTypesPkg::bgeu: taken = !flags.negu;
      default:            taken = 1'b0;
    endcase
  end

  always_comb begin
    mispredict = (execNow.kind == coreTypesPkg::conditionalType) && (predictReg != taken);

    // The decode stage already sees the corrected guess in the same cycle.
    predictNow = mispredict ? !predictReg : predictReg;
  end

  always_comb begin
    control = '0;

    if (execNow.kind == coreTypesPkg::jalrType) begin
      control.flush  = 1'b1;
      control.bypass = 1'b1;
      control.pcNext = flags.jumpTarget;
    end else if (mispredict) begin
      control.flush     = 1'b1;
      control.branch    = 1'b1;
      control.pcCurrent = execNow.pc;
      if (predictReg) begin
        control.pcNext = coreTypesPkg::word'(4); // fall through after a wrong taken guess.
      end else begin
        control.pcNext = execNow.imm;
      end
    end else begin
      // Decode-stage rules apply only when execute has nothing to correct.
      unique case (decodeNow.kind)
        coreTypesPkg::nonType: begin
          control.hold = decodeNow.isLoad; // a load needs one bubble behind it.
        end
        coreTypesPkg::jalType: begin
          control.branch    = 1'b1;
          control.hold      = 1'b1;
          control.pcNext    = decodeNow.imm;
          control.pcCurrent = decodeNow.pc;
        end
        coreTypesPkg::jalrType: begin
          control.hold = 1'b1; // the target is known only in execute.
        end
        coreTypesPkg::conditionalType: begin
          if (predictNow) begin
            control.branch    = 1'b1;
            control.hold      = 1'b1;
            control.pcNext    = decodeNow.imm;
            control.pcCurrent = decodeNow.pc;
          end
        end
        default: begin
          control.hold = 1'b0;
        end
      endcase
    end
  end

  // The squashed slot enters execute as a bubble, so flushes never come back to back.
  noBackToBackFlush : assert property (
    @(posedge Clock) disable iff (!nReset)
    control.flush |=> !control.flush
  ) else $error("branching: flush raised in two consecutive cycles.");

  // A JALR reaches execute only after it stalled fetch in decode.
  bypassAfterHold : assert property (
    @(posedge Clock) disable iff (!nReset)
    control.bypass |-> $past(control.hold)
  ) else $error("branching: bypass raised without a stall before it.");

endmodule

/* logic/pcUnit.sv */
`timescale 1ns/1ps

`include "core_params.svh"

module pcUnit (
  input  logic                      Clock,
  input  logic                      nReset,
  input  coreTypesPkg::branchingOut control,
  output coreTypesPkg::word         pc
);

  coreTypesPkg::word pcReg;
  coreTypesPkg::word pcSelect;

  // Absolute jumps win over relative redirects, which win over a stall.
  always_comb begin
    if (control.bypass) begin
      pcSelect = control.pcNext;
    end else if (control.branch) begin
      pcSelect = control.pcCurrent + control.pcNext;
    end else if (control.hold) begin
      pcSelect = pcReg;
    end else begin
      pcSelect = pcReg + coreTypesPkg::word'(4);
    end
  end

  always_ff @(posedge Clock or negedge nReset) begin
    if (!nReset) begin
      pcReg <= `CORE_RESET_PC;
    end else begin
      pcReg <= pcSelect;
    end
  end

  assign pc = pcReg;

  pcWordAligned : assert property (
    @(posedge Clock) disable iff (!nReset)
    pc[1:0] == 2'b00
  ) else $error("pcUnit: fetch address %h is not word-aligned.", pc);

endmodule

/* logic/branchSubsystem.sv */
`timescale 1ns/1ps

module branchSubsystem (
  input  logic                      Clock,
  input  logic                      nReset,
  input  coreTypesPkg::decodeBundle decodeIn,
  output coreTypesPkg::word         pc,
  output logic                      flush,
  output logic                      hold
);

  coreTypesPkg::decodeBundle decodeNow; // decode slot after replay masking.
  coreTypesPkg::decodeBundle execNow;
  coreTypesPkg::compareFlags flags;
  coreTypesPkg::branchingOut control;

  decodeExecuteStage i_decodeExecuteStage (
    .Clock     (Clock),
    .nReset    (nReset),
    .decodeIn  (decodeIn),
    .control   (control),
    .decodeNow (decodeNow),
    .execNow   (execNow)
  );

  compareUnit i_compareUnit (
    .exec  (execNow),
    .flags (flags)
  );

  branching i_branching (
    .Clock     (Clock),
    .nReset    (nReset),
    .decodeNow (decodeNow),
    .execNow   (execNow),
    .flags     (flags),
    .control   (control)
  );

  pcUnit i_pcUnit (
    .Clock   (Clock),
    .nReset  (nReset),
    .control (control),
    .pc      (pc)
  );

  assign flush = control.flush;
  assign hold  = control.hold;

endmodule

/* test/branchSubsystemTb.sv */
`timescale 1ns/1ps

`include "core_params.svh"

module branchSubsystemTb;

  localparam int ImemDepth = 64;
  localparam int WatchdogMargin = 20; // cycles for reset and redirects beyond four per instruction.

  localparam coreTypesPkg::decodeBundle Bubble = '{
    kind:   coreTypesPkg::nonType,
    cond:   coreTypesPkg::beq,
    isLoad: 1'b0,
    imm:    '0,
    pc:     '0,
    rs1:    '0,
    rs2:    '0
  };

  // Expected state of the pipeline, and the flush and hold of the cycle that led to it.
  typedef struct packed {
    coreTypesPkg::word         pc;
    logic                      replay;
    logic                      predict;
    logic                      flush;
    logic                      hold;
    coreTypesPkg::decodeBundle exec;
  } modelState;

  logic                      Clock;
  logic                      nReset;
  coreTypesPkg::decodeBundle decodeIn;
  coreTypesPkg::word         pc;
  logic                      flush;
  logic                      hold;

  coreTypesPkg::decodeBundle imem [0:ImemDepth-1]; // decoded program, indexed by pc over 4.
  int                        progLen;
  coreTypesPkg::word         endPc;
  modelState                 model;
  logic                      checking;
  logic                      testDone;
  int                        cyclesInTest;
  int                        testCount;
  int                        checkCount;
  int                        errorCount;

  branchSubsystem i_branchSubsystem (
    .Clock    (Clock),
    .nReset   (nReset),
    .decodeIn (decodeIn),
    .pc       (pc),
    .flush    (flush),
    .hold     (hold)
  );

  always #50 Clock = ~Clock;

  function automatic logic branchTaken(coreTypesPkg::branchCond cond, coreTypesPkg::word a,
                                       coreTypesPkg::word b);
    case (cond)
      coreTypesPkg::beq:  return a == b;
      coreTypesPkg::bne:  return a != b;
      coreTypesPkg::blt:  return $signed(a) < $signed(b);
      coreTypesPkg::bge:  return $signed(a) >= $signed(b);
      coreTypesPkg::bltu: return a < b;
      coreTypesPkg::bgeu: return a >= b;
      default:            return 1'b0;
    endcase
  endfunction

  // One clock of the branch rules, the replay mask and the next-PC priority.
  function automatic modelState referenceStep(modelState s, coreTypesPkg::decodeBundle fetched);
    modelState                 n;
    coreTypesPkg::decodeBundle seen;
    logic                      actual;
    logic                      relJump;
    logic                      absJump;
    coreTypesPkg::word         relBase;
    coreTypesPkg::word         relOffset;
    coreTypesPkg::word         absTarget;
    seen = s.replay ? Bubble : fetched;
    n = s;
    n.flush = 1'b0;
    n.hold = 1'b0;
    relJump = 1'b0;
    absJump = 1'b0;
    relBase = '0;
    relOffset = '0;
    absTarget = '0;
    actual = branchTaken(s.exec.cond, s.exec.rs1, s.exec.rs2);
    if (s.exec.kind == coreTypesPkg::jalrType) begin
      n.flush = 1'b1;
      absJump = 1'b1;
      absTarget = s.exec.rs1 + s.exec.imm;
    end else if (s.exec.kind == coreTypesPkg::conditionalType && actual != s.predict) begin
      n.flush = 1'b1; // wrong guess, so the predictor takes the real outcome.
      relJump = 1'b1;
      relBase = s.exec.pc;
      relOffset = actual ? s.exec.imm : 32'd4;
      n.predict = actual;
    end else if (seen.kind == coreTypesPkg::jalType ||
                 (seen.kind == coreTypesPkg::conditionalType && s.predict)) begin
      relJump = 1'b1;
      n.hold = 1'b1;
      relBase = seen.pc;
      relOffset = seen.imm;
    end else if (seen.kind == coreTypesPkg::jalrType || seen.isLoad) begin
      n.hold = 1'b1;
    end
    if (absJump) n.pc = absTarget;
    else if (relJump) n.pc = relBase + relOffset;
    else if (!n.hold) n.pc = s.pc + 32'd4;
    n.replay = n.hold && !relJump && !absJump;
    n.exec = n.flush ? Bubble : seen;
    return n;
  endfunction

  function automatic coreTypesPkg::decodeBundle fetchInstr(coreTypesPkg::word addr);
    coreTypesPkg::decodeBundle instr;
    instr = Bubble; // past the end of the program only bubbles are fetched.
    if ((addr >> 2) < progLen) instr = imem[addr >> 2];
    instr.pc = addr;
    return instr;
  endfunction

  task automatic appendInstr(coreTypesPkg::branchKind kind, coreTypesPkg::branchCond cond,
                             logic isLoad, coreTypesPkg::word imm, coreTypesPkg::word rs1,
                             coreTypesPkg::word rs2);
    imem[progLen] = '{kind: kind, cond: cond, isLoad: isLoad, imm: imm, pc: '0,
                      rs1: rs1, rs2: rs2};
    progLen = progLen + 1;
  endtask

  task automatic appendNops(int count);
    repeat (count) appendInstr(coreTypesPkg::nonType, coreTypesPkg::beq, 1'b0, '0, '0, '0);
  endtask

  task automatic runProgram(string name);
    int errorsBefore;
    errorsBefore = errorCount;
    @(posedge Clock);
    #5;
    testDone = 1'b0;
    checking = 1'b0;
    nReset = 1'b0;
    endPc = coreTypesPkg::word'(progLen * 4);
    repeat (3) @(posedge Clock);
    #5;
    nReset = 1'b1;
    model = '{pc: `CORE_RESET_PC, replay: 1'b0, predict: 1'b0, flush: 1'b0, hold: 1'b0,
              exec: Bubble};
    cyclesInTest = 0;
    checking = 1'b1;
    wait (testDone);
    testCount = testCount + 1;
    $display("test %0d %s finished with %0d errors.", testCount, name, errorCount - errorsBefore);
  endtask

  // Fetch for the address the DUT shows, a short delay after the edge.
  always @(posedge Clock) begin
    #5;
    decodeIn = fetchInstr(pc);
  end

  // Outputs are settled by the falling edge, half a cycle after the drive.
  always @(negedge Clock) begin
    if (checking) begin
      checkCount = checkCount + 1;
      if (pc !== model.pc) begin
        $display("[FAIL] %0t ns: pc expected %h actual %h", $time, model.pc, pc);
        errorCount = errorCount + 1;
      end
      if (model.pc >= endPc) begin
        checking = 1'b0;
        testDone = 1'b1;
      end else begin
        model = referenceStep(model, fetchInstr(model.pc));
        checkCount = checkCount + 2;
        if (flush !== model.flush) begin
          $display("[FAIL] %0t ns: flush expected %b actual %b", $time, model.flush, flush);
          errorCount = errorCount + 1;
        end
        if (hold !== model.hold) begin
          $display("[FAIL] %0t ns: hold expected %b actual %b", $time, model.hold, hold);
          errorCount = errorCount + 1;
        end
      end
    end
  end

  always @(posedge Clock) begin
    if (checking) begin
      cyclesInTest = cyclesInTest + 1;
      if (cyclesInTest > progLen * 4 + WatchdogMargin) begin
        $display("Watchdog: pc did not reach %h within %0d cycles.", endPc, cyclesInTest);
        $display("*** TEST FAILED ***");
        $finish;
      end
    end
  end

  initial begin
    int unsigned             seedValue;
    coreTypesPkg::word       a;
    coreTypesPkg::word       b;
    coreTypesPkg::branchCond condList [6];
    seedValue = $urandom(34);
    Clock = 1'b0;
    nReset = 1'b0;
    decodeIn = Bubble;
    checking = 1'b0;
    testDone = 1'b0;
    cyclesInTest = 0;
    testCount = 0;
    checkCount = 0;
    errorCount = 0;
    condList = '{coreTypesPkg::beq, coreTypesPkg::bne, coreTypesPkg::blt, coreTypesPkg::bge,
                 coreTypesPkg::bltu, coreTypesPkg::bgeu};

    progLen = 0;
    appendNops(8);
    runProgram("straight-line");

    progLen = 0;
    appendNops(1);
    appendInstr(coreTypesPkg::jalType, coreTypesPkg::beq, 1'b0, 32'd12, '0, '0); // lands on 16.
    appendNops(6);
    runProgram("jal");

    progLen = 0;
    appendNops(1);
    a = 32'd12 + 4 * ($urandom % 3); // keeps the target inside the program.
    appendInstr(coreTypesPkg::jalrType, coreTypesPkg::beq, 1'b0, 32'd4, a, $urandom);
    appendNops(8);
    runProgram("jalr");

    progLen = 0;
    for (int c = 0; c < 6; c++) begin
      a = $urandom;
      b = ($urandom & 32'h7fff_ffff) | (~a & 32'h8000_0000); // signs differ.
      appendInstr(coreTypesPkg::conditionalType, condList[c], 1'b0, 32'd8, a, b);
      appendNops(2);
      appendInstr(coreTypesPkg::conditionalType, condList[c], 1'b0, 32'd8, a, a);
      appendNops(2);
      b = a ^ (($urandom & 32'h7fff_ffff) | 32'd1); // same sign, different value.
      appendInstr(coreTypesPkg::conditionalType, condList[c], 1'b0, 32'd8, a, b);
      appendNops(2);
    end
    runProgram("conditions");

    progLen = 0;
    for (int r = 0; r < 5; r++) begin
      a = $urandom;
      b = a ^ ($urandom | 32'd1); // operands always differ.
      appendInstr(coreTypesPkg::conditionalType, (r < 3) ? coreTypesPkg::bne : coreTypesPkg::beq,
                  1'b0, 32'd8, a, b);
      appendNops(2);
    end
    runProgram("predictor");

    progLen = 0;
    appendNops(1);
    appendInstr(coreTypesPkg::nonType, coreTypesPkg::beq, 1'b1, '0, $urandom, $urandom);
    appendNops(2);
    appendInstr(coreTypesPkg::nonType, coreTypesPkg::beq, 1'b1, '0, $urandom, $urandom);
    appendInstr(coreTypesPkg::nonType, coreTypesPkg::beq, 1'b1, '0, $urandom, $urandom);
    appendNops(3);
    runProgram("load");

    $display("summary: %0d tests, %0d checks, %0d errors.", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+logic
logic/coreTypesPkg.sv
logic/compareUnit.sv
logic/decodeExecuteStage.sv
logic/branching.sv
logic/pcUnit.sv
logic/branchSubsystem.sv
test/branchSubsystemTb.sv

/* Bender.yml */
package:
  name: branch_subsystem

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/coreTypesPkg.sv
      - logic/compareUnit.sv
      - logic/decodeExecuteStage.sv
      - logic/branching.sv
      - logic/pcUnit.sv
      - logic/branchSubsystem.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/branchSubsystemTb.sv
